//--- Makefile
# Verilator build of the console glue testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/100ps -f build.f \
		--top-module console_io_tb -Mdir obj_dir
	./obj_dir/Vconsole_io_tb | awk '{ print } /^PASS: all tests$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- build.f
verilog/console_pkg.sv
verilog/autofire.sv
verilog/joypad_port.sv
verilog/core_reset_ctrl.sv
verilog/rom_write_port.sv
verilog/rv_word_bridge.sv
verilog/console_io_top.sv
verification/tb_clock_gen.sv
verification/console_io_tb.sv

//--- verification/console_io_tb.sv
////////////////////
// Console glue testbench
// Table of steps, toggle handshake memory model, final report
////////////////////

module console_io_tb
    import console_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TURBO_HALF = 4;
    localparam int NUM_STEPS  = 14;

    typedef enum logic [2:0] {
        OP_LOAD, OP_HOTKEY, OP_RV_WR, OP_RV_RD, OP_PAD, OP_TURBO
    } op_t;

    // One table row, exp meaning depends on op
    typedef struct packed {
        op_t         op;
        logic [22:0] addr;
        logic [31:0] data;      // Loader byte, bus data or player 2 pad
        logic [3:0]  strb;
        logic [11:0] btns;      // Player 1 pad
        logic [31:0] exp;
    } step_t;

    logic        clk;
    logic        sys_resetn;
    logic        i_loading;
    logic        i_loader_wr;
    logic [21:0] i_loader_addr;
    logic [7:0]  i_loader_data;
    mem_req_t    i_cpu_req;
    mem_req_t    o_mem_b;
    logic        i_rv_valid;
    rv_bus_t     i_rv_bus;
    logic        o_rv_ready;
    logic [31:0] o_rv_rdata;
    logic        o_rv_mem_req;
    rv_mem_req_t o_rv_mem;
    logic        i_rv_mem_ack;
    logic [15:0] i_rv_mem_dout;
    joy_btns_t   i_joy1;
    joy_btns_t   i_joy2;
    logic        i_joypad_strobe;
    logic [1:0]  i_joypad_clock;
    logic [1:0]  o_joy_data;
    logic        o_core_reset;
    logic        o_clkref;

    int          errors;
    int          checks;
    integer      seed = 32'h22e8_ce33;
    logic [15:0] mem_words [1024];  // Word model, index = addr[9:0]
    int          req_count;         // Requests seen by the model
    logic [1:0]  last_ds;
    logic        last_word;

    step_t steps [NUM_STEPS] = '{
        // Loader byte a7 at 12345, cpu req addr 0abcd data 5e oe
        '{OP_LOAD,   23'h012345, 32'h0000_00a7, 4'h0, 12'h000, 32'h02af_3579},
        // Reload while the core runs with cpu req addr 1f00f data 96 oe
        '{OP_LOAD,   23'h03c0de, 32'h0000_005b, 4'h0, 12'h000, 32'h07c0_3e59},
        '{OP_HOTKEY, 23'h0,      32'h0,         4'h0, 12'h014, 32'h1},
        '{OP_RV_WR,  23'h000100, 32'h1234_5678, 4'hf, 12'h000, 32'h2},
        '{OP_RV_RD,  23'h000100, 32'h0,         4'h0, 12'h000, 32'h1234_5678},
        '{OP_RV_WR,  23'h000100, 32'habcd_0000, 4'hc, 12'h000, 32'h1},
        '{OP_RV_WR,  23'h000100, 32'h0000_ef01, 4'h3, 12'h000, 32'h1},
        '{OP_RV_RD,  23'h000100, 32'h0,         4'h0, 12'h000, 32'habcd_ef01},
        '{OP_RV_WR,  23'h05a2c8, 32'hcafe_f00d, 4'hf, 12'h000, 32'h2},
        '{OP_RV_RD,  23'h05a2c8, 32'h0,         4'h0, 12'h000, 32'hcafe_f00d},
        // Pads, exp holds {p2 byte, p1 byte}
        '{OP_PAD,    23'h0,      32'h0000_004a, 4'h0, 12'h0b5, 32'h0000_4ab5},
        '{OP_PAD,    23'h0,      32'h0000_0c3c, 4'h0, 12'h0c3, 32'h0000_3cc3},
        // Turbo, exp holds {seen 1, seen 0}
        '{OP_TURBO,  23'h0,      32'h0,         4'h0, 12'h100, 32'h3},
        '{OP_TURBO,  23'h0,      32'h0,         4'h0, 12'h101, 32'h2}
    };

    tb_clock_gen clk_gen_i (
        .clk       (clk),
        .sys_resetn(sys_resetn)
    );

    console_io_top #(
        .AUTOFIRE_HALF(TURBO_HALF)
    ) dut_i (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_loading(i_loading), .i_loader_wr(i_loader_wr),
        .i_loader_addr(i_loader_addr), .i_loader_data(i_loader_data),
        .i_cpu_req(i_cpu_req), .o_mem_b(o_mem_b),
        .i_rv_valid(i_rv_valid), .i_rv_bus(i_rv_bus),
        .o_rv_ready(o_rv_ready), .o_rv_rdata(o_rv_rdata),
        .o_rv_mem_req(o_rv_mem_req), .o_rv_mem(o_rv_mem),
        .i_rv_mem_ack(i_rv_mem_ack), .i_rv_mem_dout(i_rv_mem_dout),
        .i_joy1(i_joy1), .i_joy2(i_joy2),
        .i_joypad_strobe(i_joypad_strobe), .i_joypad_clock(i_joypad_clock),
        .o_joy_data(o_joy_data),
        .o_core_reset(o_core_reset), .o_clkref(o_clkref)
    );

    ////////////////////
    // Memory model
    ////////////////////

    // Answers each toggle after 1 to 4 cycles
    initial begin
        rv_mem_req_t cur;
        int          delay;
        logic        pend;
        int          i;
        for (i = 0; i < 1024; i++)
            mem_words[i] = 16'(i) ^ 16'h5a3c;     // Address dependent fill
        i_rv_mem_ack  = 1'b0;
        i_rv_mem_dout = 16'h0000;
        req_count     = 0;
        pend          = 1'b0;
        delay         = 0;
        forever begin
            @(negedge clk);
            if (sys_resetn !== 1'b1) begin
                i_rv_mem_ack = 1'b0;
                pend         = 1'b0;
            end else if (pend) begin
                delay = delay - 1;
                if (delay == 0) begin
                    if (cur.we) begin
                        if (cur.ds[1]) mem_words[cur.addr[9:0]][15:8] = cur.din[15:8];
                        if (cur.ds[0]) mem_words[cur.addr[9:0]][7:0]  = cur.din[7:0];
                    end else begin
                        i_rv_mem_dout = mem_words[cur.addr[9:0]];   // Held until next
                    end
                    i_rv_mem_ack = o_rv_mem_req;
                    pend         = 1'b0;
                end
            end else if (o_rv_mem_req != i_rv_mem_ack) begin
                cur       = o_rv_mem;       // New word request
                pend      = 1'b1;
                delay     = 1 + ($random(seed) & 3);
                req_count = req_count + 1;
                last_ds   = o_rv_mem.ds;
                last_word = o_rv_mem.addr[0];
            end
        end
    end

    ////////////////////
    // Checker and helpers
    ////////////////////

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, want);
        end
    endtask

    // One softcore access, returns rdata seen with ready
    task automatic rv_access(input logic [22:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [31:0] rdata);
        int n;
        n                = 0;
        rdata            = 32'h0;
        i_rv_bus.addr    = addr;
        i_rv_bus.wdata   = data;
        i_rv_bus.wstrb   = strb;
        i_rv_valid       = 1'b1;
        @(negedge clk);
        while (!o_rv_ready && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (o_rv_ready) begin
            rdata = o_rv_rdata;
        end else begin
            errors++;
            $display("Timeout: softcore access to %h never got a ready pulse", addr);
        end
        i_rv_valid = 1'b0;
        @(negedge clk);                 // Low for one edge before next request
    endtask

    task automatic load_rom_byte(input step_t st);
        i_cpu_req = mem_req_t'(st.exp); // Read with we low, must be masked
        i_loading = 1'b1;
        @(negedge clk);
        check("o_core_reset", 32'(o_core_reset), 32'h1);
        i_loader_wr   = 1'b1;
        i_loader_addr = st.addr[21:0];
        i_loader_data = st.data[7:0];
        @(negedge clk);
        i_loader_wr = 1'b0;
        check("o_mem_b.addr", 32'(o_mem_b.addr), 32'(st.addr[21:0]));
        check("o_mem_b.wdata", 32'(o_mem_b.wdata), 32'(st.data[7:0]));
        check("o_mem_b.oe", 32'(o_mem_b.oe), 32'h0);
        check("o_mem_b.we", 32'(o_mem_b.we), 32'h1);
        @(negedge clk);
        check("o_mem_b.we", 32'(o_mem_b.we), 32'h1);     // Second cycle
        @(negedge clk);
        check("o_mem_b.we", 32'(o_mem_b.we), 32'h0);
        i_loading = 1'b0;
        @(negedge clk);
        check("o_core_reset", 32'(o_core_reset), 32'h0);
        check("o_clkref", 32'(o_clkref), 32'h1);
        @(negedge clk);
        check("o_clkref", 32'(o_clkref), 32'h0);
        @(negedge clk);
        check("o_clkref", 32'(o_clkref), 32'h1);
        check("o_mem_b", 32'(o_mem_b), st.exp);           // CPU owns port B
    endtask

    task automatic write_softcore(input step_t st);
        int          first;
        logic [31:0] rd;
        logic [9:0]  lo;
        first = req_count;
        lo    = {st.addr[10:2], 1'b0};
        rv_access(st.addr, st.data, st.strb, rd);
        check("o_rv_mem_req toggles", 32'(req_count - first), st.exp);
        // Upper word goes last whenever it is written
        check("o_rv_mem.addr[0]", 32'(last_word), 32'(|st.strb[3:2]));
        check("o_rv_mem.ds", 32'(last_ds), 32'(|st.strb[3:2] ? st.strb[3:2] : st.strb[1:0]));
        if (|st.strb[1:0])
            check("memory word 0", 32'(mem_words[lo]), 32'(st.data[15:0]));
        if (|st.strb[3:2])
            check("memory word 1", 32'(mem_words[lo + 10'd1]), 32'(st.data[31:16]));
    endtask

    task automatic read_softcore(input step_t st);
        int          first;
        logic [31:0] rd;
        first = req_count;
        rv_access(st.addr, 32'h0, 4'h0, rd);
        check("o_rv_rdata", rd, st.exp);
        check("o_rv_mem_req toggles", 32'(req_count - first), 32'h2);
        check("o_rv_mem.ds", 32'(last_ds), 32'h3);
    endtask

    // Player 1 shifts out first while player 2 holds, then player 2
    task automatic shift_pads(input step_t st);
        int         k;
        int         p;
        logic [1:0] want;
        i_joy1          = joy_btns_t'(st.btns);
        i_joy2          = joy_btns_t'(st.data[11:0]);
        i_joypad_clock  = 2'b11;
        i_joypad_strobe = 1'b1;
        @(negedge clk);
        i_joypad_strobe = 1'b0;
        @(negedge clk);
        for (p = 0; p < 2; p++) begin
            for (k = 0; k < 10; k++) begin
                if (p == 0)
                    want = {st.exp[8], ((k < 8) ? st.exp[k] : 1'b1)};
                else
                    want = {((k < 8) ? st.exp[8 + k] : 1'b1), 1'b1};   // Ones past bit 7
                check("o_joy_data", 32'(o_joy_data), 32'(want));
                i_joypad_clock[p] = 1'b0;   // Falling edge on this port only
                @(negedge clk);
                i_joypad_clock[p] = 1'b1;
                @(negedge clk);
            end
        end
        i_joy1 = '0;
        i_joy2 = '0;
    endtask

    task automatic sample_turbo(input step_t st);
        int   k;
        logic seen0;
        logic seen1;
        seen0           = 1'b0;
        seen1           = 1'b0;
        i_joy1          = joy_btns_t'(st.btns);
        i_joypad_strobe = 1'b1;         // Reload every cycle
        for (k = 0; k < 4 * TURBO_HALF; k++) begin
            @(negedge clk);
            if (o_joy_data[0])
                seen1 = 1'b1;
            else
                seen0 = 1'b1;
        end
        i_joypad_strobe = 1'b0;
        i_joy1          = '0;
        @(negedge clk);
        check("o_joy_data[0] values", 32'({seen1, seen0}), st.exp);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int idx;
        int n;
        errors          = 0;
        checks          = 0;
        i_loading       = 1'b0;
        i_loader_wr     = 1'b0;
        i_loader_addr   = '0;
        i_loader_data   = '0;
        i_cpu_req       = '0;
        i_rv_valid      = 1'b0;
        i_rv_bus        = '0;
        i_joy1          = '0;
        i_joy2          = '0;
        i_joypad_strobe = 1'b0;
        i_joypad_clock  = 2'b11;

        n = 0;
        @(negedge clk);
        while (sys_resetn !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (sys_resetn !== 1'b1) begin
            errors++;
            $display("Timeout: reset was never released");
        end
        @(negedge clk);

        for (idx = 0; idx < NUM_STEPS; idx++) begin
            case (steps[idx].op)
                OP_LOAD: load_rom_byte(steps[idx]);
                OP_HOTKEY: begin
                    i_joy1 = joy_btns_t'(steps[idx].btns);     // Select+Up
                    @(negedge clk);
                    check("o_core_reset", 32'(o_core_reset), 32'(steps[idx].exp[0]));
                    i_joy1 = '0;
                    @(negedge clk);
                    check("o_core_reset", 32'(o_core_reset), 32'(steps[idx].exp[0]));
                end
                OP_RV_WR: write_softcore(steps[idx]);
                OP_RV_RD: read_softcore(steps[idx]);
                OP_PAD:   shift_pads(steps[idx]);
                OP_TURBO: sample_turbo(steps[idx]);
                default: begin
                    errors++;
                    $display("Step %0d has an unknown operation", idx);
                end
            endcase
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
////////////////////
// Testbench clock and reset
// 20 ns clock, reset held low for two cycles
////////////////////

module tb_clock_gen (
    output logic clk,
    output logic sys_resetn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 50 MHz
    end

    initial begin
        sys_resetn = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);             // Release away from the active edge
        sys_resetn = 1'b1;
    end

endmodule

//--- verilog/autofire.sv
////////////////////
// Turbo oscillator
// Square wave of presses while a button is held
////////////////////

module autofire #(
    parameter int AUTOFIRE_HALF = 8
) (
    input  logic clk,
    input  logic sys_resetn,
    input  logic i_btn,
    output logic o_fire
);

    localparam int CNT_W = $clog2(AUTOFIRE_HALF + 1);

    logic [CNT_W-1:0] cnt;
    logic             phase;    // High during released half

    always_ff @(posedge clk) begin
        if (!sys_resetn || !i_btn) begin
            cnt   <= '0;
            phase <= 1'b0;
        end else if (cnt == CNT_W'(AUTOFIRE_HALF - 1)) begin
            cnt   <= '0;
            phase <= ~phase;    // Half period done
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_fire = i_btn & ~phase;     // Pressed on first held cycle

endmodule

//--- verilog/console_io_top.sv
////////////////////
// Console glue top level
// Reset control, loader port, softcore bridge and pads
////////////////////

module console_io_top
    import console_pkg::*;
#(
    parameter int AUTOFIRE_HALF = AUTOFIRE_HALF_DEF
) (
    input  logic        clk,
    input  logic        sys_resetn,
    // Loader
    input  logic        i_loading,
    input  logic        i_loader_wr,
    input  logic [21:0] i_loader_addr,
    input  logic [7:0]  i_loader_data,
    // Core memory traffic
    input  mem_req_t    i_cpu_req,
    output mem_req_t    o_mem_b,
    // Softcore bus
    input  logic        i_rv_valid,
    input  rv_bus_t     i_rv_bus,
    output logic        o_rv_ready,
    output logic [31:0] o_rv_rdata,
    // Softcore memory words
    output logic        o_rv_mem_req,
    output rv_mem_req_t o_rv_mem,
    input  logic        i_rv_mem_ack,
    input  logic [15:0] i_rv_mem_dout,
    // Pads
    input  joy_btns_t   i_joy1,
    input  joy_btns_t   i_joy2,
    input  logic        i_joypad_strobe,
    input  logic [1:0]  i_joypad_clock,
    output logic [1:0]  o_joy_data,
    // Core control
    output logic        o_core_reset,
    output logic        o_clkref
);

    core_reset_ctrl u_reset_ctrl (
        .clk         (clk),
        .sys_resetn  (sys_resetn),
        .i_loading   (i_loading),
        .i_joy1      (i_joy1),
        .o_core_reset(o_core_reset),
        .o_clkref    (o_clkref)
    );

    rom_write_port u_rom_wr (
        .clk          (clk),
        .sys_resetn   (sys_resetn),
        .i_loading    (i_loading),
        .i_loader_wr  (i_loader_wr),
        .i_loader_addr(i_loader_addr),
        .i_loader_data(i_loader_data),
        .i_cpu_req    (i_cpu_req),
        .o_mem_b      (o_mem_b)
    );

    rv_word_bridge u_rv_bridge (
        .clk       (clk),
        .sys_resetn(sys_resetn),
        .i_rv_valid(i_rv_valid),
        .i_rv_bus  (i_rv_bus),
        .o_rv_ready(o_rv_ready),
        .o_rv_rdata(o_rv_rdata),
        .o_mem_req (o_rv_mem_req),
        .o_mem     (o_rv_mem),
        .i_mem_ack (i_rv_mem_ack),
        .i_mem_dout(i_rv_mem_dout)
    );

    // Player 1 and player 2 ports
    joypad_port #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_pad1 (
        .clk(clk), .sys_resetn(sys_resetn), .i_btns(i_joy1),
        .i_strobe(i_joypad_strobe), .i_clock(i_joypad_clock[0]), .o_data(o_joy_data[0])
    );

    joypad_port #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_pad2 (
        .clk(clk), .sys_resetn(sys_resetn), .i_btns(i_joy2),
        .i_strobe(i_joypad_strobe), .i_clock(i_joypad_clock[1]), .o_data(o_joy_data[1])
    );

endmodule

//--- verilog/console_pkg.sv
////////////////////
// Console glue package
// Pad button layout, memory port requests and softcore bus types
////////////////////

package console_pkg;

    ////////////////////
    // Controller buttons
    ////////////////////

    // SNES layout, lower byte is the NES button byte
    typedef struct packed {
        logic r;
        logic l;
        logic x;        // Turbo source for y slot
        logic a;        // Turbo source for b slot
        logic rt;
        logic lt;
        logic dn;
        logic up;
        logic start;
        logic select;
        logic y;
        logic b;
    } joy_btns_t;

    ////////////////////
    // Memory port B
    ////////////////////

    typedef struct packed {
        logic [21:0] addr;
        logic [7:0]  wdata;
        logic        we;
        logic        oe;
    } mem_req_t;

    ////////////////////
    // Softcore side
    ////////////////////

    typedef struct packed {
        logic [22:0] addr;      // Byte address
        logic [31:0] wdata;
        logic [3:0]  wstrb;     // All zero means read
    } rv_bus_t;

    // One 16-bit word toward memory
    typedef struct packed {
        logic [19:0] addr;      // Byte addr 20..2 plus word select
        logic [15:0] din;
        logic [1:0]  ds;        // Byte selects
        logic        we;
    } rv_mem_req_t;

    // Turbo half period in clocks
    localparam int AUTOFIRE_HALF_DEF = 8;

endpackage

//--- verilog/core_reset_ctrl.sv
////////////////////
// Core reset and clock reference
// Holds the core in reset during ROM loads and on Select+Up
////////////////////

module core_reset_ctrl
    import console_pkg::*;
(
    input  logic      clk,
    input  logic      sys_resetn,
    input  logic      i_loading,
    input  joy_btns_t i_joy1,
    output logic      o_core_reset,
    output logic      o_clkref
);

    logic loading_r;    // Previous loading level
    logic load_start;
    logic load_end;
    logic hotkey;

    assign load_start = i_loading & ~loading_r;
    assign load_end   = ~i_loading & loading_r;
    assign hotkey     = i_joy1.select & i_joy1.up;   // Player 1 only

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_r    <= 1'b0;
            o_core_reset <= 1'b1;       // Core held until first load ends
            o_clkref     <= 1'b0;
        end else begin
            loading_r <= i_loading;
            o_clkref  <= ~o_clkref;     // Half rate reference

            // Hotkey wins over a load ending in the same cycle
            if (hotkey) begin
                o_core_reset <= 1'b1;
            end else if (load_end) begin
                o_core_reset <= 1'b0;
                o_clkref     <= 1'b1;   // Restart in phase with release
            end else if (load_start) begin
                o_core_reset <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/joypad_port.sv
////////////////////
// NES joypad port
// Parallel-in serial-out pad register with turbo on a and x
////////////////////

module joypad_port
    import console_pkg::*;
#(
    parameter int AUTOFIRE_HALF = 8
) (
    input  logic      clk,
    input  logic      sys_resetn,
    input  joy_btns_t i_btns,
    input  logic      i_strobe,
    input  logic      i_clock,
    output logic      o_data
);

    logic       fire_a;
    logic       fire_x;
    logic       clock_r;
    logic       clock_fall;
    logic [7:0] shift;

    autofire #(
        .AUTOFIRE_HALF(AUTOFIRE_HALF)
    ) u_turbo_a (
        .clk       (clk),
        .sys_resetn(sys_resetn),
        .i_btn     (i_btns.a),
        .o_fire    (fire_a)
    );

    autofire #(
        .AUTOFIRE_HALF(AUTOFIRE_HALF)
    ) u_turbo_x (
        .clk       (clk),
        .sys_resetn(sys_resetn),
        .i_btn     (i_btns.x),
        .o_fire    (fire_x)
    );

    assign clock_fall = ~i_clock & clock_r;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            clock_r <= 1'b0;        // No false edge out of reset
            shift   <= 8'hff;       // Reads as released pad
        end else begin
            clock_r <= i_clock;
            if (i_strobe)
                shift <= {i_btns[7:2], i_btns.y | fire_x, i_btns.b | fire_a};
            else if (clock_fall)
                shift <= {1'b1, shift[7:1]};   // Ones after the last bit
        end
    end

    assign o_data = shift[0];

endmodule

//--- verilog/rom_write_port.sv
////////////////////
// Loader write port
// Latches loader bytes, stretches the strobe, muxes port B
////////////////////

module rom_write_port
    import console_pkg::*;
(
    input  logic        clk,
    input  logic        sys_resetn,
    input  logic        i_loading,
    input  logic        i_loader_wr,
    input  logic [21:0] i_loader_addr,
    input  logic [7:0]  i_loader_data,
    input  mem_req_t    i_cpu_req,
    output mem_req_t    o_mem_b
);

    logic        wr_r;          // Strobe delayed one clock
    logic        wr_stretch;    // Two clock write enable
    logic [21:0] ld_addr;
    logic [7:0]  ld_data;

    ////////////////////
    // Strobe stretch
    ////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            wr_r       <= 1'b0;
            wr_stretch <= 1'b0;
        end else begin
            wr_r       <= i_loader_wr;
            wr_stretch <= i_loader_wr | wr_r;   // Arbiter runs slower
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (i_loader_wr) begin
            ld_addr <= i_loader_addr;
            ld_data <= i_loader_data;
        end
    end

    ////////////////////
    // Port B select
    ////////////////////

    always_comb begin
        o_mem_b    = i_cpu_req;
        o_mem_b.we = i_cpu_req.we | wr_stretch;
        if (i_loading) begin
            o_mem_b.addr  = ld_addr;
            o_mem_b.wdata = ld_data;
            o_mem_b.oe    = 1'b0;       // No CPU reads mid load
        end
    end

endmodule

//--- verilog/rv_word_bridge.sv
////////////////////
// Softcore to memory bridge
// Splits 32-bit accesses into two 16-bit words
// Toggle req/ack toward memory, ready pulse toward the softcore
////////////////////

module rv_word_bridge
    import console_pkg::*;
(
    input  logic        clk,
    input  logic        sys_resetn,
    input  logic        i_rv_valid,
    input  rv_bus_t     i_rv_bus,
    output logic        o_rv_ready,
    output logic [31:0] o_rv_rdata,
    output logic        o_mem_req,
    output rv_mem_req_t o_mem,
    input  logic        i_mem_ack,
    input  logic [15:0] i_mem_dout
);

    typedef enum logic [2:0] {
        ST_IDLE_REQ0  = 3'd0,   // Wait for request, issue word 0
        ST_WAIT0_REQ1 = 3'd1,   // Wait word 0, issue word 1
        ST_DATA0      = 3'd2,   // Capture word 0
        ST_WAIT1      = 3'd3,
        ST_DATA1      = 3'd4
    } rv_state_t;

    rv_state_t   state;
    logic        valid_r;
    logic        new_req;       // Edge seen while busy
    logic        new_req_edge;
    logic        is_write;
    logic        acked;         // Memory caught up with toggle
    logic        word_sel;      // 0 lower, 1 upper
    logic [1:0]  ds;
    logic [15:0] dout0;         // Lower read word

    assign new_req_edge = i_rv_valid & ~valid_r;
    assign is_write     = |i_rv_bus.wstrb;
    assign acked        = (o_mem_req == i_mem_ack);

    ////////////////////
    // Request fields
    ////////////////////

    assign o_mem.addr = {i_rv_bus.addr[20:2], word_sel};
    assign o_mem.din  = word_sel ? i_rv_bus.wdata[31:16] : i_rv_bus.wdata[15:0];
    assign o_mem.ds   = ds;
    assign o_mem.we   = is_write;

    assign o_rv_rdata = {i_mem_dout, dout0};   // Memory holds word 1

    ////////////////////
    // FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state      <= ST_IDLE_REQ0;
            valid_r    <= 1'b0;
            new_req    <= 1'b0;
            o_rv_ready <= 1'b0;
            o_mem_req  <= 1'b0;
            word_sel   <= 1'b0;
            ds         <= 2'b00;
        end else begin
            valid_r    <= i_rv_valid;
            o_rv_ready <= 1'b0;
            if (new_req_edge)
                new_req <= 1'b1;            // Keep it if busy

            case (state)
                ST_IDLE_REQ0: begin
                    if (new_req || new_req_edge) begin
                        new_req   <= 1'b0;
                        o_mem_req <= ~o_mem_req;
                        if (is_write && i_rv_bus.wstrb[1:0] == 2'b00) begin
                            word_sel <= 1'b1;   // Upper half only
                            ds       <= i_rv_bus.wstrb[3:2];
                            state    <= ST_WAIT1;
                        end else begin
                            word_sel <= 1'b0;
                            ds       <= is_write ? i_rv_bus.wstrb[1:0] : 2'b11;
                            state    <= ST_WAIT0_REQ1;
                        end
                    end
                end

                ST_WAIT0_REQ1: begin
                    if (acked) begin
                        word_sel <= 1'b1;
                        if (!is_write) begin
                            o_mem_req <= ~o_mem_req;   // Read word 1
                            ds        <= 2'b11;
                            state     <= ST_DATA0;
                        end else if (i_rv_bus.wstrb[3:2] == 2'b00) begin
                            o_rv_ready <= 1'b1;        // Lower half only
                            state      <= ST_IDLE_REQ0;
                        end else begin
                            o_mem_req <= ~o_mem_req;
                            ds        <= i_rv_bus.wstrb[3:2];
                            state     <= ST_WAIT1;
                        end
                    end
                end

                ST_DATA0: begin
                    dout0 <= i_mem_dout;    // Still word 0 until ack
                    state <= ST_WAIT1;
                end

                ST_WAIT1: begin
                    if (acked) begin
                        if (is_write) begin
                            o_rv_ready <= 1'b1;
                            state      <= ST_IDLE_REQ0;
                        end else begin
                            state <= ST_DATA1;
                        end
                    end
                end

                ST_DATA1: begin
                    o_rv_ready <= 1'b1;
                    state      <= ST_IDLE_REQ0;
                end

                default: state <= ST_IDLE_REQ0;
            endcase
        end
    end

endmodule
